//--- design/byte_sbox.sv
// AES byte substitution
`timescale 1ns/1ps
`default_nettype none

module byte_sbox #(
	parameter bit INVERSE = 1'b0
) (
	input  logic [7:0] in_byte,
	output logic [7:0] out_byte
);

	localparam logic [0:255][7:0] FWD_TABLE = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [0:255][7:0] INV_TABLE = {
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	assign out_byte = INVERSE ? INV_TABLE[in_byte] : FWD_TABLE[in_byte];

endmodule

`default_nettype wire

//--- design/inv_aes_pkg.sv
// AES-128 decryption core definitions
`default_nettype none

package inv_aes_pkg;

	localparam int BLOCK_W    = 128;
	localparam int NUM_ROUNDS = 10;
	localparam int NUM_COLS   = 4;

	// Byte 0 is the leftmost byte of the block
	typedef logic [0:BLOCK_W/8-1][7:0] block_t;

	// One state column, row 0 first
	typedef logic [0:NUM_COLS-1][7:0] word_t;

	typedef logic [1:0] col_idx_t;
	typedef logic [3:0] key_idx_t;        // Round keys 0 to 10

	typedef enum logic [2:0] {
		IDLE,
		EXPAND,
		ADD_FIRST,
		SHIFT_SUB,
		ADD_KEY,
		MIX,
		DONE
	} ctrl_state_t;

	// Round constants, indexed by the round key being derived
	localparam logic [1:NUM_ROUNDS][7:0] RCON = {
		8'h01,
		8'h02,
		8'h04,
		8'h08,
		8'h10,
		8'h20,
		8'h40,
		8'h80,
		8'h1b,
		8'h36
	};

endpackage

`default_nettype wire

//--- design/inv_aes_top.sv
// AES-128 decryption core
`timescale 1ns/1ps
`default_nettype none

module inv_aes_top (
	input  logic                clk,
	input  logic                Reset,
	input  logic                run,
	input  inv_aes_pkg::block_t ciphertext,
	input  inv_aes_pkg::block_t cipher_key,
	output inv_aes_pkg::block_t plaintext,
	output logic                ready
);
	import inv_aes_pkg::*;

	logic   key_start;
	logic   key_done;
	block_t round_key;

	round_ctrl_if cmd_if ();

	round_ctrl u_ctrl (
		.clk       (clk),
		.Reset     (Reset),
		.run       (run),
		.key_done  (key_done),
		.key_start (key_start),
		.ready     (ready),
		.cmd       (cmd_if.ctrl)
	);

	key_schedule u_keys (
		.clk        (clk),
		.Reset      (Reset),
		.key_start  (key_start),
		.cipher_key (cipher_key),
		.key_idx    (cmd_if.key_idx),
		.key_done   (key_done),
		.round_key  (round_key)
	);

	inv_round_datapath u_dp (
		.clk        (clk),
		.Reset      (Reset),
		.ciphertext (ciphertext),
		.round_key  (round_key),
		.cmd        (cmd_if.dp),
		.state      (plaintext)
	);

endmodule

`default_nettype wire

//--- design/inv_mix_column.sv
// Inverse MixColumns for one column
`timescale 1ns/1ps
`default_nettype none

module inv_mix_column (
	input  inv_aes_pkg::word_t in_col,
	output inv_aes_pkg::word_t out_col
);
	import inv_aes_pkg::*;

	word_t x2;
	word_t x4;
	word_t x8;

	// Multiply by 2 in GF(2^8)
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	always_comb begin
		for (int i = 0; i < NUM_COLS; i++) begin
			x2[i] = xtime(in_col[i]);
			x4[i] = xtime(x2[i]);
			x8[i] = xtime(x4[i]);
		end
	end

	// Row r takes 0e, 0b, 0d, 09 starting at byte r
	always_comb begin
		for (int r = 0; r < NUM_COLS; r++) begin
			out_col[r] = (x8[r] ^ x4[r] ^ x2[r])
				^ (x8[(r + 1) % 4] ^ x2[(r + 1) % 4] ^ in_col[(r + 1) % 4])
				^ (x8[(r + 2) % 4] ^ x4[(r + 2) % 4] ^ in_col[(r + 2) % 4])
				^ (x8[(r + 3) % 4] ^ in_col[(r + 3) % 4]);
		end
	end

endmodule

`default_nettype wire

//--- design/inv_round_datapath.sv
// Inverse cipher round datapath
`timescale 1ns/1ps
`default_nettype none

module inv_round_datapath (
	input  logic                clk,
	input  logic                Reset,
	input  inv_aes_pkg::block_t ciphertext,
	input  inv_aes_pkg::block_t round_key,
	round_ctrl_if.dp            cmd,
	output inv_aes_pkg::block_t state
);
	import inv_aes_pkg::*;

	block_t shifted;
	block_t subbed;
	word_t  mix_in;
	word_t  mix_out;

	// InvShiftRows, row r rotates right by r
	always_comb begin
		for (int c = 0; c < NUM_COLS; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted[4 * c + r] = state[4 * ((c - r + 4) % 4) + r];
			end
		end
	end

	for (genvar i = 0; i < BLOCK_W / 8; i++) begin : g_inv_sbox
		byte_sbox #(
			.INVERSE (1'b1)
		) u_inv_sbox (
			.in_byte  (shifted[i]),
			.out_byte (subbed[i])
		);
	end

	assign mix_in = state[{cmd.col_idx, 2'b00} +: 4];

	inv_mix_column u_mix (
		.in_col  (mix_in),
		.out_col (mix_out)
	);

	always_ff @(posedge clk or negedge Reset) begin
		if (!Reset) begin
			state <= '0;
		end else if (cmd.load) begin
			state <= ciphertext ^ round_key;
		end else if (cmd.add_key) begin
			state <= state ^ round_key;
		end else if (cmd.shift_sub) begin
			state <= subbed;
		end else if (cmd.mix) begin
			state[{cmd.col_idx, 2'b00} +: 4] <= mix_out;        // One column per cycle
		end
	end

	a_mix_col_known: assert property (
		@(posedge clk) disable iff (!Reset)
		cmd.mix |-> !$isunknown(cmd.col_idx)
	);

endmodule

`default_nettype wire

//--- design/key_schedule.sv
// AES-128 key expansion
`timescale 1ns/1ps
`default_nettype none

module key_schedule (
	input  logic                  clk,
	input  logic                  Reset,
	input  logic                  key_start,
	input  inv_aes_pkg::block_t   cipher_key,
	input  inv_aes_pkg::key_idx_t key_idx,
	output logic                  key_done,
	output inv_aes_pkg::block_t   round_key
);
	import inv_aes_pkg::*;

	block_t   rk_mem [0:NUM_ROUNDS];
	block_t   last_key;
	block_t   next_key;
	word_t    rot_word;
	word_t    sub_word;
	word_t    temp_word;
	key_idx_t key_cnt;        // Key being derived
	logic     busy;

	// RotWord on the last word of the previous key
	assign rot_word = {last_key[13], last_key[14], last_key[15], last_key[12]};

	for (genvar i = 0; i < 4; i++) begin : g_sbox
		byte_sbox #(
			.INVERSE (1'b0)
		) u_sbox (
			.in_byte  (rot_word[i]),
			.out_byte (sub_word[i])
		);
	end

	assign temp_word = sub_word ^ {RCON[key_cnt], 24'h000000};

	always_comb begin
		next_key[0 +: 4]  = last_key[0 +: 4] ^ temp_word;
		next_key[4 +: 4]  = last_key[4 +: 4] ^ next_key[0 +: 4];
		next_key[8 +: 4]  = last_key[8 +: 4] ^ next_key[4 +: 4];
		next_key[12 +: 4] = last_key[12 +: 4] ^ next_key[8 +: 4];
	end

	always_ff @(posedge clk or negedge Reset) begin
		if (!Reset) begin
			busy    <= 1'b0;
			key_cnt <= '0;
		end else if (key_start) begin
			busy    <= 1'b1;
			key_cnt <= key_idx_t'(1);
		end else if (busy) begin
			if (key_cnt == key_idx_t'(NUM_ROUNDS))
				busy <= 1'b0;
			else
				key_cnt <= key_cnt + key_idx_t'(1);
		end
	end

	// Key store
	always_ff @(posedge clk) begin
		if (key_start) begin
			rk_mem[0] <= cipher_key;
			last_key  <= cipher_key;
		end else if (busy) begin
			rk_mem[key_cnt] <= next_key;
			last_key        <= next_key;
		end
	end

	// High while the last round key is written
	assign key_done = busy && (key_cnt == key_idx_t'(NUM_ROUNDS));

	assign round_key = rk_mem[key_idx];

endmodule

`default_nettype wire

//--- design/round_ctrl.sv
// Decryption sequencer
`timescale 1ns/1ps
`default_nettype none

module round_ctrl (
	input  logic       clk,
	input  logic       Reset,
	input  logic       run,
	input  logic       key_done,
	output logic       key_start,
	output logic       ready,
	round_ctrl_if.ctrl cmd
);
	import inv_aes_pkg::*;

	ctrl_state_t state;
	key_idx_t    rnd_cnt;        // Counts 9 down to 0
	col_idx_t    col_cnt;

	always_ff @(posedge clk or negedge Reset) begin
		if (!Reset) begin
			state   <= IDLE;
			rnd_cnt <= '0;
			col_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (run) begin
						state   <= EXPAND;
						rnd_cnt <= key_idx_t'(NUM_ROUNDS - 1);
					end
				end
				EXPAND: begin
					if (key_done)
						state <= ADD_FIRST;
				end
				ADD_FIRST: state <= SHIFT_SUB;
				SHIFT_SUB: state <= ADD_KEY;
				ADD_KEY: begin
					col_cnt <= '0;
					if (rnd_cnt == '0)
						state <= DONE;        // Final round has no mix
					else
						state <= MIX;
				end
				MIX: begin
					col_cnt <= col_cnt + col_idx_t'(1);
					if (col_cnt == col_idx_t'(NUM_COLS - 1)) begin
						state   <= SHIFT_SUB;
						rnd_cnt <= rnd_cnt - key_idx_t'(1);
					end
				end
				DONE: begin
					if (!run)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign key_start = (state == IDLE) && run;
	assign ready     = (state == DONE);

	assign cmd.load      = (state == ADD_FIRST);
	assign cmd.shift_sub = (state == SHIFT_SUB);
	assign cmd.add_key   = (state == ADD_KEY);
	assign cmd.mix       = (state == MIX);
	assign cmd.col_idx   = col_cnt;
	assign cmd.key_idx   = (state == ADD_FIRST) ? key_idx_t'(NUM_ROUNDS) : rnd_cnt;

	a_cmd_onehot: assert property (
		@(posedge clk) disable iff (!Reset)
		$onehot0({cmd.load, cmd.add_key, cmd.shift_sub, cmd.mix})
	);

	a_key_idx_range: assert property (
		@(posedge clk) disable iff (!Reset)
		cmd.key_idx <= key_idx_t'(NUM_ROUNDS)
	);

	// Ready only follows the add of round key 0
	a_ready_after_last_add: assert property (
		@(posedge clk) disable iff (!Reset)
		$rose(ready) |-> $past(cmd.add_key && cmd.key_idx == '0)
	);

endmodule

`default_nettype wire

//--- design/round_ctrl_if.sv
// Round command interface
`timescale 1ns/1ps
`default_nettype none

interface round_ctrl_if;
	import inv_aes_pkg::*;

	logic     load;        // Ciphertext XOR last round key
	logic     add_key;
	logic     shift_sub;
	logic     mix;
	col_idx_t col_idx;
	key_idx_t key_idx;

	modport ctrl (
		output load,
		output add_key,
		output shift_sub,
		output mix,
		output col_idx,
		output key_idx
	);

	modport dp (
		input load,
		input add_key,
		input shift_sub,
		input mix,
		input col_idx,
		input key_idx
	);

endinterface

`default_nettype wire

//--- src.f
design/inv_aes_pkg.sv
design/round_ctrl_if.sv
design/byte_sbox.sv
design/inv_mix_column.sv
design/key_schedule.sv
design/inv_round_datapath.sv
design/round_ctrl.sv
design/inv_aes_top.sv
testbench/tb_inv_aes.sv

//--- testbench/tb_inv_aes.sv
// AES-128 decryption testbench
`timescale 1ns/1ps
`default_nettype none

module tb_inv_aes;
	import inv_aes_pkg::*;

	localparam int LATENCY      = 67;
	localparam int READY_LIMIT  = 200;        // Cycles allowed per wait
	localparam int NUM_ALT_RUNS = 6;

	// FIPS-197 appendix C.1
	localparam block_t C1_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam block_t C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
	localparam block_t C1_PT  = 128'h00112233445566778899aabbccddeeff;

	// FIPS-197 appendix B
	localparam block_t B_CT  = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam block_t B_KEY = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam block_t B_PT  = 128'h3243f6a8885a308d313198a2e0370734;

	logic   clk;
	logic   Reset;
	logic   run;
	block_t ciphertext;
	block_t cipher_key;
	block_t plaintext;
	logic   ready;

	block_t exp_plain;
	block_t prev_plain;        // Plaintext one edge earlier
	string  test_name;
	int     run_edges;
	int     assert_errors;
	int     timeouts;
	bit     aborted;
	integer seed;

	inv_aes_top dut_i (
		.clk        (clk),
		.Reset      (Reset),
		.run        (run),
		.ciphertext (ciphertext),
		.cipher_key (cipher_key),
		.plaintext  (plaintext),
		.ready      (ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Edges with run high, frozen once ready is seen
	always @(posedge clk or negedge Reset) begin
		if (!Reset)
			run_edges <= 0;
		else if (!run)
			run_edges <= 0;
		else if (!ready)
			run_edges <= run_edges + 1;
	end

	always @(posedge clk)
		prev_plain <= plaintext;

	a_idle_ready_low: assert property (
		@(posedge clk) disable iff (!Reset)
		!run |=> !ready
	) else begin
		assert_errors++;
		$display("[FAIL] %s ready_low expected 0 actual %b", test_name, $sampled(ready));
	end

	// Ready is first sampled one edge after it rises
	a_latency: assert property (
		@(posedge clk) disable iff (!Reset)
		$rose(ready) |-> run_edges == LATENCY + 1
	) else begin
		assert_errors++;
		$display("[FAIL] %s latency expected %0d actual %0d", test_name, LATENCY,
			$sampled(run_edges) - 1);
	end

	a_plain_value: assert property (
		@(posedge clk) disable iff (!Reset)
		ready |-> plaintext == exp_plain
	) else begin
		assert_errors++;
		$display("[FAIL] %s plaintext expected %h actual %h", test_name, exp_plain,
			$sampled(plaintext));
	end

	a_ready_held: assert property (
		@(posedge clk) disable iff (!Reset)
		ready && run |=> ready
	) else begin
		assert_errors++;
		$display("[FAIL] %s ready_held expected 1 actual %b", test_name, $sampled(ready));
	end

	// Nothing may touch the state in DONE or IDLE
	a_plain_held: assert property (
		@(posedge clk) disable iff (!Reset)
		ready || !run |=> plaintext == prev_plain
	) else begin
		assert_errors++;
		$display("[FAIL] %s plain_held expected %h actual %h", test_name,
			$sampled(prev_plain), $sampled(plaintext));
	end

	task automatic wait_ready(input logic level, output bit ok);
		int n;
		n = 0;
		while (ready !== level && n < READY_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		ok = (ready === level);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// One block: idle gap, run until ready, hold, then drop run
	task automatic decrypt(input string name, input block_t ct, input block_t key,
			input block_t pt, input int gap, input int hold);
		bit ok;
		if (aborted)
			return;
		idle_cycles(gap);
		test_name  = name;
		exp_plain  = pt;
		ciphertext = ct;
		cipher_key = key;
		run        = 1'b1;
		wait_ready(1'b1, ok);
		if (!ok) begin
			timeouts++;
			aborted = 1'b1;
			$display("%s: ready never rose after run", name);
			return;
		end
		idle_cycles(hold);
		run = 1'b0;
		wait_ready(1'b0, ok);
		if (!ok) begin
			timeouts++;
			aborted = 1'b1;
			$display("%s: ready never fell after run dropped", name);
		end
	endtask

	initial begin
		int gap;
		int hold;
		Reset         = 1'b0;
		run           = 1'b0;
		ciphertext    = '0;
		cipher_key    = '0;
		exp_plain     = '0;
		test_name     = "reset";
		assert_errors = 0;
		timeouts      = 0;
		aborted       = 1'b0;
		seed          = 32'h3f6d_06d7;

		repeat (3) @(posedge clk);
		#1;
		Reset = 1'b1;
		idle_cycles(10);        // Run low, ready must stay low

		decrypt("fips_c1", C1_CT, C1_KEY, C1_PT, 0, 0);
		decrypt("fips_b", B_CT, B_KEY, B_PT, 3, 5);

		for (int i = 0; i < NUM_ALT_RUNS; i++) begin
			gap  = ($random(seed) & 7) + 1;
			hold = $random(seed) & 3;
			if (i % 2 == 0)
				decrypt($sformatf("alt_c1_%0d", i), C1_CT, C1_KEY, C1_PT, gap, hold);
			else
				decrypt($sformatf("alt_b_%0d", i), B_CT, B_KEY, B_PT, gap, hold);
		end

		idle_cycles(4);
		$display("errors: %0d assertion failures, %0d timeouts", assert_errors, timeouts);
		if (assert_errors == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
